// ==== axi_pkg.sv ====
package axi_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths with a meaning
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [1:0]  resp_t;

    // Transaction ids of the two masters
    localparam axi_id_t ID_DATA = 4'd0;
    localparam axi_id_t ID_INST = 4'd1;

    localparam resp_t      RESP_OKAY  = 2'b00;
    localparam logic [2:0] SIZE_8B    = 3'b011;
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [3:0] CACHE_MOD  = 4'b0010;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4 channel payloads, valid and ready travel beside them
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic [3:0] cache;
        logic [2:0] prot;
        logic [3:0] qos;
    } axi_aw_t;

    typedef struct packed {
        data_t      data;
        logic [7:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        resp_t   resp;
    } axi_b_t;

    // Read address carries the same fields as write address
    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        axi_id_t id;
        data_t   data;
        resp_t   resp;
        logic    last;
    } axi_r_t;

    // One beat of 8 bytes, INCR, no burst
    function automatic axi_aw_t single_beat(axi_id_t id, addr_t addr);
        axi_aw_t req;
        req       = '0;
        req.id    = id;
        req.addr  = addr;
        req.size  = SIZE_8B;
        req.burst = BURST_INCR;
        req.cache = CACHE_MOD;
        return req;
    endfunction

endpackage

// ==== sim_memory.sv ====
module sim_memory
    import axi_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  write_ena,
    input  addr_t write_addr,
    input  data_t write_data,
    input  logic  read_data_ena,
    input  logic  read_inst_ena,
    input  addr_t read_addr,
    output data_t data_out,
    output inst_t inst_out
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t             mem [MEM_WORDS];
    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  rd_idx;
    data_t             rd_word;

    // Word index sits just above the byte offset
    assign wr_idx = write_addr[IDX_W+2:3];
    assign rd_idx = read_addr[IDX_W+2:3];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write_ena) begin
            mem[wr_idx] <= write_data;
        end
    end

    assign rd_word  = mem[rd_idx];
    assign data_out = read_data_ena ? rd_word : '0;

    // Bit 2 picks the upper instruction of the word
    assign inst_out = !read_inst_ena ? '0 : (read_addr[2] ? rd_word[63:32] : rd_word[31:0]);

endmodule

// ==== axi_mem_slave.sv ====
module axi_mem_slave
    import axi_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready,
    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready,
    output logic    write_ena,
    output addr_t   write_addr,
    output data_t   write_data,
    output logic    read_data_ena,
    output logic    read_inst_ena,
    output addr_t   read_addr,
    input  data_t   data_out,
    input  inst_t   inst_out
);

    typedef enum logic [1:0] {W_IDLE, W_INFO, W_RESP} wr_state_t;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_t;

    wr_state_t wr_state;
    wr_state_t wr_state_nxt;
    rd_state_t rd_state;
    rd_state_t rd_state_nxt;

    axi_id_t wr_id_q;
    addr_t   wr_addr_q;
    data_t   wr_data_q;
    axi_id_t rd_id_q;
    addr_t   rd_addr_q;

    logic wr_take;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // AW and W are only taken as a pair
    assign aw_ready = (wr_state != W_RESP) && aw_valid && w_valid;
    assign w_ready  = aw_ready;
    assign wr_take  = aw_valid && aw_ready;
    assign b_hs     = b_valid && b_ready;

    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            W_IDLE: begin
                if (wr_take) wr_state_nxt = W_RESP;
                else if (aw_valid || w_valid) wr_state_nxt = W_INFO;
            end
            W_INFO: if (wr_take) wr_state_nxt = W_RESP;
            W_RESP: if (b_hs) wr_state_nxt = W_IDLE;
            default: wr_state_nxt = W_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) wr_state <= W_IDLE;
        else wr_state <= wr_state_nxt;
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            wr_id_q   <= aw.id;
            wr_addr_q <= aw.addr;
            wr_data_q <= w.data;
        end
    end

    // The memory write repeats while B waits, which is harmless
    assign b_valid    = (wr_state == W_RESP);
    assign b          = '{id: wr_id_q, resp: RESP_OKAY};
    assign write_ena  = (wr_state == W_RESP);
    assign write_addr = write_ena ? wr_addr_q : '0;
    assign write_data = write_ena ? wr_data_q : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ar_ready = (rd_state != R_DATA);
    assign ar_hs    = ar_valid && ar_ready;
    assign r_hs     = r_valid && r_ready;

    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            R_IDLE: begin
                if (ar_hs) rd_state_nxt = R_DATA;
                else if (ar_valid) rd_state_nxt = R_ADDR;
            end
            R_ADDR: if (ar_hs) rd_state_nxt = R_DATA;
            R_DATA: if (r_hs) rd_state_nxt = R_IDLE;
            default: rd_state_nxt = R_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) rd_state <= R_IDLE;
        else rd_state <= rd_state_nxt;
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_id_q   <= ar.id;
            rd_addr_q <= ar.addr;
        end
    end

    assign read_data_ena = (rd_state == R_DATA) && (rd_id_q == ID_DATA);
    assign read_inst_ena = (rd_state == R_DATA) && (rd_id_q == ID_INST);
    assign read_addr     = (rd_state == R_DATA) ? rd_addr_q : '0;

    // Instruction reads come back zero-extended
    assign r_valid = (rd_state == R_DATA);
    assign r.id    = rd_id_q;
    assign r.data  = read_data_ena ? data_out : (read_inst_ena ? {32'b0, inst_out} : '0);
    assign r.resp  = RESP_OKAY;
    assign r.last  = (rd_state == R_DATA);

endmodule

// ==== axi_arbiter.sv ====
module axi_arbiter
    import axi_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // Fetch master, read only
    input  axi_ar_t f_ar,
    input  logic    f_ar_valid,
    output logic    f_ar_ready,
    output axi_r_t  f_r,
    output logic    f_r_valid,
    input  logic    f_r_ready,
    // Load/store master
    input  axi_aw_t l_aw,
    input  logic    l_aw_valid,
    output logic    l_aw_ready,
    input  axi_w_t  l_w,
    input  logic    l_w_valid,
    output logic    l_w_ready,
    output axi_b_t  l_b,
    output logic    l_b_valid,
    input  logic    l_b_ready,
    input  axi_ar_t l_ar,
    input  logic    l_ar_valid,
    output logic    l_ar_ready,
    output axi_r_t  l_r,
    output logic    l_r_valid,
    input  logic    l_r_ready,
    // Shared bus towards the slave
    output axi_aw_t s_aw,
    output logic    s_aw_valid,
    input  logic    s_aw_ready,
    output axi_w_t  s_w,
    output logic    s_w_valid,
    input  logic    s_w_ready,
    input  axi_b_t  s_b,
    input  logic    s_b_valid,
    output logic    s_b_ready,
    output axi_ar_t s_ar,
    output logic    s_ar_valid,
    input  logic    s_ar_ready,
    input  axi_r_t  s_r,
    input  logic    s_r_valid,
    output logic    s_r_ready
);

    logic open_q;
    logic owner_lsu_q;
    logic last_lsu_q;
    logic fetch_req;
    logic lsu_req;
    logic pick_lsu;
    logic owner_lsu;
    logic close;

    assign fetch_req = f_ar_valid;
    assign lsu_req   = l_ar_valid || l_aw_valid || l_w_valid;

    // On a tie the master that was not served last wins
    assign pick_lsu  = lsu_req && (!fetch_req || !last_lsu_q);
    assign owner_lsu = open_q ? owner_lsu_q : pick_lsu;
    assign close     = (s_b_valid && s_b_ready) || (s_r_valid && s_r_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            open_q      <= 1'b0;
            owner_lsu_q <= 1'b0;
            last_lsu_q  <= 1'b0;
        end else if (!open_q && (fetch_req || lsu_req)) begin
            open_q      <= 1'b1;
            owner_lsu_q <= pick_lsu;
            last_lsu_q  <= pick_lsu;
        end else if (close) begin
            open_q <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request channels, the fetch master has no write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign s_aw       = l_aw;
    assign s_aw_valid = owner_lsu && l_aw_valid;
    assign s_w        = l_w;
    assign s_w_valid  = owner_lsu && l_w_valid;
    assign s_ar       = owner_lsu ? l_ar : f_ar;
    assign s_ar_valid = owner_lsu ? l_ar_valid : f_ar_valid;

    assign l_aw_ready = owner_lsu && s_aw_ready;
    assign l_w_ready  = owner_lsu && s_w_ready;
    assign l_ar_ready = owner_lsu && s_ar_ready;
    assign f_ar_ready = !owner_lsu && s_ar_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Responses go back to the owner only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign l_b       = s_b;
    assign l_b_valid = owner_lsu && s_b_valid;
    assign s_b_ready = owner_lsu && l_b_ready;

    assign f_r       = s_r;
    assign l_r       = s_r;
    assign f_r_valid = !owner_lsu && s_r_valid;
    assign l_r_valid = owner_lsu && s_r_valid;
    assign s_r_ready = owner_lsu ? l_r_ready : f_r_ready;

endmodule

// ==== fetch_port.sv ====
module fetch_port
    import axi_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    fetch_req,
    input  addr_t   fetch_addr,
    output logic    fetch_busy,
    output logic    fetch_done,
    output inst_t   fetch_inst,
    output axi_ar_t ar,
    output logic    ar_valid,
    input  logic    ar_ready,
    input  axi_r_t  r,
    input  logic    r_valid,
    output logic    r_ready
);

    typedef enum logic [1:0] {IDLE, ADDR, WAIT} state_t;

    state_t state;
    addr_t  addr_q;
    logic   r_hit;

    // Only the instruction response closes a fetch
    assign r_hit = r_valid && (r.id == ID_INST);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                IDLE: if (fetch_req) state <= ADDR;
                ADDR: if (ar_ready) state <= WAIT;
                WAIT: begin
                    if (r_hit) begin
                        state      <= IDLE;
                        fetch_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fetch_req) addr_q <= fetch_addr;
        if (state == WAIT && r_hit) fetch_inst <= r.data[31:0];
    end

    assign fetch_busy = (state != IDLE);
    assign ar         = single_beat(ID_INST, addr_q);
    assign ar_valid   = (state == ADDR);
    assign r_ready    = 1'b1;

endmodule

// ==== lsu_port.sv ====
module lsu_port
    import axi_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    lsu_load,
    input  logic    lsu_store,
    input  addr_t   lsu_addr,
    input  data_t   lsu_wdata,
    output logic    lsu_busy,
    output logic    lsu_done,
    output data_t   lsu_rdata,
    output axi_aw_t aw,
    output logic    aw_valid,
    input  logic    aw_ready,
    output axi_w_t  w,
    output logic    w_valid,
    input  logic    w_ready,
    input  axi_b_t  b,
    input  logic    b_valid,
    output logic    b_ready,
    output axi_ar_t ar,
    output logic    ar_valid,
    input  logic    ar_ready,
    input  axi_r_t  r,
    input  logic    r_valid,
    output logic    r_ready
);

    typedef enum logic [1:0] {IDLE, ADDR, WAIT} state_t;

    state_t state;
    logic   store_q;
    addr_t  addr_q;
    data_t  wdata_q;
    logic   accepted;
    logic   resp_hit;

    // A store waits for B, a load for R
    assign accepted = store_q ? (aw_ready && w_ready) : ar_ready;
    assign resp_hit = store_q ? (b_valid && b.id == ID_DATA) : (r_valid && r.id == ID_DATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            store_q  <= 1'b0;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (lsu_load || lsu_store) begin
                        state   <= ADDR;
                        store_q <= lsu_store;
                    end
                end
                ADDR: if (accepted) state <= WAIT;
                WAIT: begin
                    if (resp_hit) begin
                        state    <= IDLE;
                        lsu_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && (lsu_load || lsu_store)) begin
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
        end
        if (state == WAIT && resp_hit && !store_q) lsu_rdata <= r.data;
    end

    assign lsu_busy = (state != IDLE);

    assign aw       = single_beat(ID_DATA, addr_q);
    assign aw_valid = (state == ADDR) && store_q;
    assign w        = '{data: wdata_q, strb: 8'hff, last: 1'b1};
    assign w_valid  = (state == ADDR) && store_q;
    assign ar       = single_beat(ID_DATA, addr_q);
    assign ar_valid = (state == ADDR) && !store_q;
    assign b_ready  = 1'b1;
    assign r_ready  = 1'b1;

endmodule

// ==== soc_mem_top.sv ====
module soc_mem_top
    import axi_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    output logic  fetch_busy,
    output logic  fetch_done,
    output inst_t fetch_inst,
    input  logic  lsu_load,
    input  logic  lsu_store,
    input  addr_t lsu_addr,
    input  data_t lsu_wdata,
    output logic  lsu_busy,
    output logic  lsu_done,
    output data_t lsu_rdata
);

    axi_ar_t f_ar;
    axi_r_t  f_r;
    logic    f_ar_valid, f_ar_ready, f_r_valid, f_r_ready;

    axi_aw_t l_aw;
    axi_w_t  l_w;
    axi_b_t  l_b;
    axi_ar_t l_ar;
    axi_r_t  l_r;
    logic    l_aw_valid, l_aw_ready, l_w_valid, l_w_ready, l_b_valid, l_b_ready;
    logic    l_ar_valid, l_ar_ready, l_r_valid, l_r_ready;

    axi_aw_t s_aw;
    axi_w_t  s_w;
    axi_b_t  s_b;
    axi_ar_t s_ar;
    axi_r_t  s_r;
    logic    s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
    logic    s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;

    logic    write_ena, read_data_ena, read_inst_ena;
    addr_t   write_addr, read_addr;
    data_t   write_data, data_out;
    inst_t   inst_out;

    fetch_port fetch_i (
        .clk, .reset, .fetch_req, .fetch_addr, .fetch_busy, .fetch_done, .fetch_inst,
        .ar(f_ar), .ar_valid(f_ar_valid), .ar_ready(f_ar_ready),
        .r(f_r), .r_valid(f_r_valid), .r_ready(f_r_ready)
    );

    lsu_port lsu_i (
        .clk, .reset, .lsu_load, .lsu_store, .lsu_addr, .lsu_wdata,
        .lsu_busy, .lsu_done, .lsu_rdata,
        .aw(l_aw), .aw_valid(l_aw_valid), .aw_ready(l_aw_ready),
        .w(l_w), .w_valid(l_w_valid), .w_ready(l_w_ready),
        .b(l_b), .b_valid(l_b_valid), .b_ready(l_b_ready),
        .ar(l_ar), .ar_valid(l_ar_valid), .ar_ready(l_ar_ready),
        .r(l_r), .r_valid(l_r_valid), .r_ready(l_r_ready)
    );

    axi_arbiter arbiter_i (.*);

    axi_mem_slave slave_i (
        .clk, .reset,
        .aw(s_aw), .aw_valid(s_aw_valid), .aw_ready(s_aw_ready),
        .w(s_w), .w_valid(s_w_valid), .w_ready(s_w_ready),
        .b(s_b), .b_valid(s_b_valid), .b_ready(s_b_ready),
        .ar(s_ar), .ar_valid(s_ar_valid), .ar_ready(s_ar_ready),
        .r(s_r), .r_valid(s_r_valid), .r_ready(s_r_ready),
        .write_ena, .write_addr, .write_data,
        .read_data_ena, .read_inst_ena, .read_addr, .data_out, .inst_out
    );

    sim_memory #(.MEM_WORDS(MEM_WORDS)) memory_i (
        .clk, .reset, .write_ena, .write_addr, .write_data,
        .read_data_ena, .read_inst_ena, .read_addr, .data_out, .inst_out
    );

endmodule

// ==== tb_soc_mem_properties.sv ====
module tb_soc_mem_properties
    import axi_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input axi_aw_t s_aw,
    input logic    s_aw_valid,
    input logic    s_aw_ready,
    input axi_w_t  s_w,
    input logic    s_w_valid,
    input logic    s_w_ready,
    input axi_ar_t s_ar,
    input logic    s_ar_valid,
    input logic    s_ar_ready,
    input logic    s_b_valid,
    input axi_r_t  s_r,
    input logic    s_r_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench top to end the run on a protocol error
    int unsigned fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared bus between the arbiter and the slave
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    aw_hold: assert property (@(posedge clk) disable iff (reset)
        s_aw_valid && !s_aw_ready |=> s_aw_valid && $stable(s_aw))
        else begin
            fail_count++;
            $error("AW valid dropped or AW payload changed before acceptance");
        end

    w_hold: assert property (@(posedge clk) disable iff (reset)
        s_w_valid && !s_w_ready |=> s_w_valid && $stable(s_w))
        else begin
            fail_count++;
            $error("W valid dropped or W payload changed before acceptance");
        end

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        s_ar_valid && !s_ar_ready |=> s_ar_valid && $stable(s_ar))
        else begin
            fail_count++;
            $error("AR valid dropped or AR payload changed before acceptance");
        end

    // Only one transaction is ever open on the bus
    one_response: assert property (@(posedge clk) disable iff (reset)
        !(s_b_valid && s_r_valid))
        else begin
            fail_count++;
            $error("B valid and R valid are high in the same cycle");
        end

    r_last: assert property (@(posedge clk) disable iff (reset)
        s_r_valid |-> s_r.last)
        else begin
            fail_count++;
            $error("R valid is high while R last is low");
        end

endmodule

bind soc_mem_top tb_soc_mem_properties props_i (
    .clk(clk),
    .reset(reset),
    .s_aw(s_aw),
    .s_aw_valid(s_aw_valid),
    .s_aw_ready(s_aw_ready),
    .s_w(s_w),
    .s_w_valid(s_w_valid),
    .s_w_ready(s_w_ready),
    .s_ar(s_ar),
    .s_ar_valid(s_ar_valid),
    .s_ar_ready(s_ar_ready),
    .s_b_valid(s_b_valid),
    .s_r(s_r),
    .s_r_valid(s_r_valid)
);

// ==== tb_soc_mem.sv ====
module tb_soc_mem
    import axi_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS     = 256;
    localparam int RESET_CYCLES  = 4;
    localparam int N_STORES      = 40;
    localparam int N_LOADS       = 40;
    localparam int N_FETCHES     = 30;
    localparam int N_ROUNDS      = 20;
    localparam int CYCLES_PER_OP = 20;
    // Each round is two operations and every second round adds a lone load
    localparam int N_OPS = N_STORES + N_LOADS + N_FETCHES + 2 * N_ROUNDS + N_ROUNDS / 2;
    localparam int TIMEOUT_CYCLES = CYCLES_PER_OP * N_OPS + RESET_CYCLES;

    logic  clk;
    logic  reset;
    logic  fetch_req;
    addr_t fetch_addr;
    logic  fetch_busy;
    logic  fetch_done;
    inst_t fetch_inst;
    logic  lsu_load;
    logic  lsu_store;
    addr_t lsu_addr;
    data_t lsu_wdata;
    logic  lsu_busy;
    logic  lsu_done;
    data_t lsu_rdata;

    integer seed;
    int     cycles = 0;
    data_t  ref_mem [MEM_WORDS];
    addr_t  store_addr [N_STORES];
    logic   started;
    logic   contended;
    logic   load_open;
    data_t  exp_rdata;
    inst_t  exp_inst;

    soc_mem_top #(.MEM_WORDS(MEM_WORDS)) dut_i (.*);

    always #5 clk = ~clk;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    function automatic int word_of(addr_t a);
        return int'(a[10:3]);
    endfunction

    // Bit 2 of the address selects the upper half of the word
    function automatic inst_t half_at(addr_t a);
        return a[2] ? ref_mem[word_of(a)][63:32] : ref_mem[word_of(a)][31:0];
    endfunction

    function automatic addr_t rand_word_addr();
        logic [7:0] idx;
        idx = 8'($random(seed));
        return {53'b0, idx, 3'b0};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks sampled on the rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !started |-> !fetch_busy && !lsu_busy && !fetch_done && !lsu_done)
        else fail_run($sformatf("Error: before any request fetch_busy=%h lsu_busy=%h %s=%h %s=%h",
            $sampled(fetch_busy), $sampled(lsu_busy), "fetch_done", $sampled(fetch_done),
            "lsu_done", $sampled(lsu_done)));

    load_data: assert property (@(posedge clk) disable iff (reset)
        lsu_done && load_open |-> lsu_rdata == exp_rdata)
        else fail_run($sformatf("Error: lsu_rdata = %h, expected %h",
            $sampled(lsu_rdata), exp_rdata));

    fetch_data: assert property (@(posedge clk) disable iff (reset)
        fetch_done |-> fetch_inst == exp_inst)
        else fail_run($sformatf("Error: fetch_inst = %h, expected %h",
            $sampled(fetch_inst), exp_inst));

    // Done lands on the fourth clock counting the one that takes the request
    lsu_latency: assert property (@(posedge clk) disable iff (reset)
        !contended && (lsu_load || lsu_store) |-> ##1 !lsu_done ##1 !lsu_done ##1 lsu_done)
        else fail_run("lsu_done did not pulse exactly 4 cycles after an uncontended request");

    fetch_latency: assert property (@(posedge clk) disable iff (reset)
        !contended && fetch_req |-> ##1 !fetch_done ##1 !fetch_done ##1 fetch_done)
        else fail_run("fetch_done did not pulse exactly 4 cycles after an uncontended request");

    pair_fetch_bound: assert property (@(posedge clk) disable iff (reset)
        contended && fetch_req |-> ##[1:12] fetch_done)
        else fail_run("fetch_done did not arrive within 12 cycles under contention");

    pair_load_bound: assert property (@(posedge clk) disable iff (reset)
        contended && lsu_load |-> ##[1:12] lsu_done)
        else fail_run("lsu_done did not arrive within 12 cycles under contention");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("The run timed out before all operations finished");
        end else if (dut_i.props_i.fail_count != 0) begin
            fail_run("A bus protocol assertion failed");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side stimulus driven on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The extra edge keeps the expectations in place while done is sampled
    task automatic wait_lsu_done();
        while (!lsu_done) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic wait_fetch_done();
        while (!fetch_done) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic issue_store(addr_t a, data_t d);
        started = 1'b1;
        load_open = 1'b0;
        ref_mem[word_of(a)] = d;
        lsu_addr = a;
        lsu_wdata = d;
        lsu_store = 1'b1;
        @(negedge clk);
        lsu_store = 1'b0;
        wait_lsu_done();
    endtask

    task automatic issue_load(addr_t a);
        started = 1'b1;
        load_open = 1'b1;
        exp_rdata = ref_mem[word_of(a)];
        lsu_addr = a;
        lsu_load = 1'b1;
        @(negedge clk);
        lsu_load = 1'b0;
        wait_lsu_done();
    endtask

    task automatic issue_fetch(addr_t a);
        started = 1'b1;
        exp_inst = half_at(a);
        fetch_addr = a;
        fetch_req = 1'b1;
        @(negedge clk);
        fetch_req = 1'b0;
        wait_fetch_done();
    endtask

    task automatic fetch_with_load(addr_t fa, addr_t la);
        logic got_fetch;
        logic got_load;
        got_fetch = 1'b0;
        got_load = 1'b0;
        contended = 1'b1;
        load_open = 1'b1;
        exp_inst = half_at(fa);
        exp_rdata = ref_mem[word_of(la)];
        fetch_addr = fa;
        lsu_addr = la;
        fetch_req = 1'b1;
        lsu_load = 1'b1;
        @(negedge clk);
        fetch_req = 1'b0;
        lsu_load = 1'b0;
        while (!got_fetch || !got_load) begin
            @(negedge clk);
            got_fetch = got_fetch || fetch_done;
            got_load = got_load || lsu_done;
        end
        @(negedge clk);
        contended = 1'b0;
    endtask

    initial begin
        seed = 32'h7e1ae829;
        clk = 1'b0;
        reset = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        lsu_load = 1'b0;
        lsu_store = 1'b0;
        lsu_addr = '0;
        lsu_wdata = '0;
        started = 1'b0;
        contended = 1'b0;
        load_open = 1'b0;
        exp_rdata = '0;
        exp_inst = '0;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);

        for (int i = 0; i < N_STORES; i++) begin
            store_addr[i] = rand_word_addr();
            issue_store(store_addr[i], {$random(seed), $random(seed)});
        end
        // Half the loads hit stored words and the rest mostly untouched ones
        for (int i = 0; i < N_LOADS; i++) begin
            issue_load((i % 2 == 0) ? store_addr[i % N_STORES] : rand_word_addr());
        end
        for (int i = 0; i < N_FETCHES; i++) begin
            issue_fetch(store_addr[i % N_STORES] | (addr_t'(i % 2) << 2));
        end
        // A lone load beforehand lets the fetch master win the next tie
        for (int i = 0; i < N_ROUNDS; i++) begin
            if (i % 2 == 1) issue_load(store_addr[i]);
            fetch_with_load(store_addr[i] | 64'h4, store_addr[N_STORES - 1 - i]);
        end

        repeat (5) @(negedge clk);
        if (dut_i.props_i.fail_count != 0) begin
            fail_run("A bus protocol assertion failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
axi_pkg.sv
sim_memory.sv
axi_mem_slave.sv
axi_arbiter.sv
fetch_port.sv
lsu_port.sv
soc_mem_top.sv
tb_soc_mem_properties.sv
tb_soc_mem.sv
